/* hdl/vread_pkg.sv */
package vread_pkg;

   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int SYM_W      = 16;
   localparam int SYMS       = AXI_DATA_W / SYM_W;
   localparam int REG_ADDR_W = 8;

   // buffer word, whole or as output symbols; symbol 0 is the low half
   typedef union packed {
      logic [AXI_DATA_W-1:0]      word;
      logic [SYMS-1:0][SYM_W-1:0] sym;
   } word_u;

   localparam logic [REG_ADDR_W-1:0] REG_CTRL      = 8'h00;
   localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 8'h04;
   localparam logic [REG_ADDR_W-1:0] REG_EXT_ADDR  = 8'h08;
   localparam logic [REG_ADDR_W-1:0] REG_RD_LEN    = 8'h0c;
   localparam logic [REG_ADDR_W-1:0] REG_RD_PER    = 8'h10;
   localparam logic [REG_ADDR_W-1:0] REG_RD_DUTY   = 8'h14;
   localparam logic [REG_ADDR_W-1:0] REG_RD_INCR   = 8'h18;
   localparam logic [REG_ADDR_W-1:0] REG_RD_ITER   = 8'h1c;
   localparam logic [REG_ADDR_W-1:0] REG_RD_SHIFT  = 8'h20;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_START = 8'h24;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_PER   = 8'h28;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_DUTY  = 8'h2c;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_INCR  = 8'h30;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_ITER  = 8'h34;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_SHIFT = 8'h38;
   localparam logic [REG_ADDR_W-1:0] REG_OUT_DELAY = 8'h3c;

   localparam int CTRL_RUN      = 0;
   localparam int CTRL_READ_EN  = 1;
   localparam int CTRL_PINGPONG = 2;

endpackage

/* hdl/vread_ifs.sv */
`timescale 1ns/1ps

interface vread_cfg_if #(
   parameter int ADDR_W   = 10,
   parameter int PERIOD_W = 8,
   parameter int LEN_W    = 8,
   parameter int DELAY_W  = 7
);
   logic [vread_pkg::AXI_ADDR_W-1:0] ext_addr;
   logic [LEN_W-1:0]                 rd_len;
   logic [PERIOD_W-1:0]              rd_per;
   logic [PERIOD_W-1:0]              rd_duty;
   logic [ADDR_W-1:0]                rd_incr;
   logic [ADDR_W-1:0]                rd_iter;
   logic [ADDR_W-1:0]                rd_shift;
   logic [ADDR_W-1:0]                out_start;
   logic [PERIOD_W-1:0]              out_per;
   logic [PERIOD_W-1:0]              out_duty;
   logic [ADDR_W-1:0]                out_incr;
   logic [ADDR_W-1:0]                out_iter;
   logic [ADDR_W-1:0]                out_shift;
   logic [DELAY_W-1:0]               delay;
   logic                             read_en;
   logic                             pingpong;
   // one-cycle launch pulse
   logic                             run;
   logic                             done;

   modport regs (
      output ext_addr, rd_len, rd_per, rd_duty, rd_incr, rd_iter, rd_shift,
      output out_start, out_per, out_duty, out_incr, out_iter, out_shift,
      output delay, read_en, pingpong, run,
      input  done
   );

   modport unit (
      input  ext_addr, rd_len, rd_per, rd_duty, rd_incr, rd_iter, rd_shift,
      input  out_start, out_per, out_duty, out_incr, out_iter, out_shift,
      input  delay, read_en, pingpong, run,
      output done
   );
endinterface

interface mem_2p_if #(
   parameter int ADDR_W = 10
);
   logic                             we;
   logic [ADDR_W-1:0]                waddr;
   logic [vread_pkg::AXI_DATA_W-1:0] wdata;
   logic                             re;
   logic [ADDR_W-1:0]                raddr;
   logic [vread_pkg::AXI_DATA_W-1:0] rdata;

   modport ctrl (output we, waddr, wdata, re, raddr, input rdata);
   modport mem (input we, waddr, wdata, re, raddr, output rdata);
endinterface

/* hdl/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen #(
   parameter int ADDR_W   = 10,
   parameter int PERIOD_W = 8,
   parameter int DELAY_W  = 7
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  logic [ADDR_W-1:0]   start_i,
   input  logic [PERIOD_W-1:0] per_i,
   input  logic [PERIOD_W-1:0] duty_i,
   input  logic [ADDR_W-1:0]   incr_i,
   input  logic [ADDR_W-1:0]   iter_i,
   input  logic [ADDR_W-1:0]   shift_i,
   input  logic [DELAY_W-1:0]  delay_i,
   input  logic                ready_i,
   output logic                valid_o,
   output logic [ADDR_W-1:0]   addr_o,
   output logic                done_o
);

   logic                busy;
   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] per_cnt;
   logic [ADDR_W-1:0]   iter_cnt;
   logic [ADDR_W-1:0]   base;
   logic                walking;
   logic                step;
   logic                per_end;
   logic                iter_end;

   assign walking  = busy && (delay_cnt == '0);
   assign valid_o  = walking && (per_cnt < duty_i);
   // steps outside the duty window advance without a handshake
   assign step     = walking && (ready_i || !valid_o);
   assign per_end  = (per_cnt == per_i - PERIOD_W'(1));
   assign iter_end = (iter_cnt == iter_i - ADDR_W'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         done_o    <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (run_i) begin
            busy      <= 1'b1;
            delay_cnt <= delay_i;
            per_cnt   <= '0;
            iter_cnt  <= '0;
         end else if (busy && delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end else if (step) begin
            if (per_end) begin
               per_cnt <= '0;
               if (iter_end) begin
                  busy   <= 1'b0;
                  done_o <= 1'b1;
               end else begin
                  iter_cnt <= iter_cnt + 1'b1;
               end
            end else begin
               per_cnt <= per_cnt + 1'b1;
            end
         end
      end
   end

   // shift is the stride between period start addresses
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_o <= start_i;
         base   <= start_i;
      end else if (step) begin
         if (per_end) begin
            addr_o <= base + shift_i;
            base   <= base + shift_i;
         end else begin
            addr_o <= addr_o + incr_i;
         end
      end
   end

endmodule

/* hdl/mem_writer.sv */
`timescale 1ns/1ps

module mem_writer #(
   parameter int ADDR_W = 10
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             gen_valid_i,
   input  logic [ADDR_W-1:0]                gen_addr_i,
   output logic                             gen_ready_o,
   input  logic                             bus_valid_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0] bus_data_i,
   output logic                             bus_ready_o,
   mem_2p_if.ctrl                           mem
);

   logic              have_addr;
   logic [ADDR_W-1:0] addr_q;
   logic              beat;

   assign bus_ready_o = have_addr;
   assign beat        = bus_valid_i && have_addr;
   // refill in the same cycle the held address is consumed
   assign gen_ready_o = !have_addr || beat;

   assign mem.we    = beat;
   assign mem.waddr = addr_q;
   assign mem.wdata = bus_data_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         have_addr <= 1'b0;
      end else if (gen_ready_o) begin
         have_addr <= gen_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (gen_ready_o) begin
         addr_q <= gen_addr_i;
      end
   end

endmodule

/* hdl/vread_unit.sv */
`timescale 1ns/1ps

module vread_unit #(
   parameter int ADDR_W   = 10,
   parameter int PERIOD_W = 8,
   parameter int LEN_W    = 8,
   parameter int DELAY_W  = 7
) (
   input  logic                             clk,
   input  logic                             rst,
   vread_cfg_if.unit                        cfg,
   mem_2p_if.ctrl                           mem,
   input  logic                             databus_ready_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0] databus_rdata_i,
   input  logic                             databus_last_i,
   output logic                             databus_valid_o,
   output logic [vread_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   output logic [LEN_W-1:0]                 databus_len_o,
   output logic                             out_valid_o,
   output logic [vread_pkg::SYM_W-1:0]      out_data_o
);

   localparam int SEL_W = $clog2(vread_pkg::SYMS);

   logic              pp_state;
   logic              read_done;
   logic              out_done;
   logic [ADDR_W-1:0] rd_start;
   logic [ADDR_W-1:0] out_start_pp;
   logic              gen_valid;
   logic              gen_ready;
   logic [ADDR_W-1:0] gen_addr;
   logic              wr_bus_ready;
   logic              last_beat;
   logic              out_re;
   logic [ADDR_W-1:0] out_addr;
   logic              out_gen_done;
   logic [ADDR_W-1:0] out_word;
   logic [SEL_W-1:0]  sel_q;
   vread_pkg::word_u  rd_word;

   // top address bit picks the half; fill and drain use opposite halves
   assign rd_start     = {cfg.pingpong && !pp_state, {(ADDR_W-1){1'b0}}};
   assign out_start_pp = {cfg.pingpong && pp_state, cfg.out_start[ADDR_W-2:0]};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (cfg.run) begin
         pp_state <= cfg.pingpong ? !pp_state : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         databus_addr_o <= '0;
      end else if (cfg.run && cfg.read_en) begin
         databus_addr_o <= cfg.ext_addr;
      end
   end

   assign databus_len_o   = cfg.rd_len;
   assign databus_valid_o = wr_bus_ready && !read_done;
   assign last_beat       = databus_valid_o && databus_ready_i && databus_last_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         read_done <= 1'b1;
         out_done  <= 1'b1;
      end else if (cfg.run) begin
         read_done <= !cfg.read_en;
         out_done  <= 1'b0;
      end else begin
         if (last_beat) begin
            read_done <= 1'b1;
         end
         if (out_gen_done) begin
            out_done <= 1'b1;
         end
      end
   end

   assign cfg.done = read_done && out_done;

   addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) read_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (cfg.run && cfg.read_en),
      .start_i(rd_start),
      .per_i  (cfg.rd_per),
      .duty_i (cfg.rd_duty),
      .incr_i (cfg.rd_incr),
      .iter_i (cfg.rd_iter),
      .shift_i(cfg.rd_shift),
      .delay_i({DELAY_W{1'b0}}),
      .ready_i(gen_ready),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o ()
   );

   mem_writer #(
      .ADDR_W(ADDR_W)
   ) writer (
      .clk        (clk),
      .rst        (rst),
      .gen_valid_i(gen_valid),
      .gen_addr_i (gen_addr),
      .gen_ready_o(gen_ready),
      .bus_valid_i(databus_ready_i && !read_done),
      .bus_data_i (databus_rdata_i),
      .bus_ready_o(wr_bus_ready),
      .mem        (mem)
   );

   addr_gen #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .DELAY_W (DELAY_W)
   ) out_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (cfg.run),
      .start_i(out_start_pp),
      .per_i  (cfg.out_per),
      .duty_i (cfg.out_duty),
      .incr_i (cfg.out_incr),
      .iter_i (cfg.out_iter),
      .shift_i(cfg.out_shift),
      .delay_i(cfg.delay),
      .ready_i(1'b1),
      .valid_o(out_re),
      .addr_o (out_addr),
      .done_o (out_gen_done)
   );

   // symbol address to word address, half bit kept on top
   always_comb begin
      out_word = '0;
      out_word[ADDR_W-SEL_W-2:0] = out_addr[ADDR_W-2:SEL_W];
      out_word[ADDR_W-1]         = cfg.pingpong && out_addr[ADDR_W-1];
   end

   assign mem.re    = out_re;
   assign mem.raddr = out_word;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= out_re;
      end
   end

   // lines up with the memory read latency
   always_ff @(posedge clk) begin
      sel_q <= out_addr[SEL_W-1:0];
   end

   assign rd_word    = mem.rdata;
   assign out_data_o = rd_word.sym[sel_q];

endmodule

/* hdl/vread_regs.sv */
`timescale 1ns/1ps

module vread_regs #(
   parameter int ADDR_W   = 10,
   parameter int PERIOD_W = 8,
   parameter int LEN_W    = 8,
   parameter int DELAY_W  = 7
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [vread_pkg::REG_ADDR_W-1:0] paddr_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0] pwdata_i,
   output logic [vread_pkg::AXI_DATA_W-1:0] prdata_o,
   output logic                             pready_o,
   vread_cfg_if.regs                        cfg
);

   logic wr_en;

   assign wr_en    = psel_i && penable_i && pwrite_i;
   // no wait states
   assign pready_o = 1'b1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg.run       <= 1'b0;
         cfg.read_en   <= 1'b0;
         cfg.pingpong  <= 1'b0;
         cfg.ext_addr  <= '0;
         cfg.rd_len    <= '0;
         cfg.rd_per    <= '0;
         cfg.rd_duty   <= '0;
         cfg.rd_incr   <= '0;
         cfg.rd_iter   <= '0;
         cfg.rd_shift  <= '0;
         cfg.out_start <= '0;
         cfg.out_per   <= '0;
         cfg.out_duty  <= '0;
         cfg.out_incr  <= '0;
         cfg.out_iter  <= '0;
         cfg.out_shift <= '0;
         cfg.delay     <= '0;
      end else begin
         // run is a pulse and never reads back
         cfg.run <= 1'b0;
         if (wr_en) begin
            case (paddr_i)
               vread_pkg::REG_CTRL: begin
                  cfg.run      <= pwdata_i[vread_pkg::CTRL_RUN];
                  cfg.read_en  <= pwdata_i[vread_pkg::CTRL_READ_EN];
                  cfg.pingpong <= pwdata_i[vread_pkg::CTRL_PINGPONG];
               end
               vread_pkg::REG_EXT_ADDR:  cfg.ext_addr  <= pwdata_i;
               vread_pkg::REG_RD_LEN:    cfg.rd_len    <= pwdata_i[LEN_W-1:0];
               vread_pkg::REG_RD_PER:    cfg.rd_per    <= pwdata_i[PERIOD_W-1:0];
               vread_pkg::REG_RD_DUTY:   cfg.rd_duty   <= pwdata_i[PERIOD_W-1:0];
               vread_pkg::REG_RD_INCR:   cfg.rd_incr   <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_RD_ITER:   cfg.rd_iter   <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_RD_SHIFT:  cfg.rd_shift  <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_OUT_START: cfg.out_start <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_OUT_PER:   cfg.out_per   <= pwdata_i[PERIOD_W-1:0];
               vread_pkg::REG_OUT_DUTY:  cfg.out_duty  <= pwdata_i[PERIOD_W-1:0];
               vread_pkg::REG_OUT_INCR:  cfg.out_incr  <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_OUT_ITER:  cfg.out_iter  <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_OUT_SHIFT: cfg.out_shift <= pwdata_i[ADDR_W-1:0];
               vread_pkg::REG_OUT_DELAY: cfg.delay     <= pwdata_i[DELAY_W-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (psel_i && !pwrite_i) begin
         case (paddr_i)
            vread_pkg::REG_CTRL: begin
               prdata_o[vread_pkg::CTRL_READ_EN]  = cfg.read_en;
               prdata_o[vread_pkg::CTRL_PINGPONG] = cfg.pingpong;
            end
            vread_pkg::REG_STATUS:    prdata_o[0]            = cfg.done;
            vread_pkg::REG_EXT_ADDR:  prdata_o               = cfg.ext_addr;
            vread_pkg::REG_RD_LEN:    prdata_o[LEN_W-1:0]    = cfg.rd_len;
            vread_pkg::REG_RD_PER:    prdata_o[PERIOD_W-1:0] = cfg.rd_per;
            vread_pkg::REG_RD_DUTY:   prdata_o[PERIOD_W-1:0] = cfg.rd_duty;
            vread_pkg::REG_RD_INCR:   prdata_o[ADDR_W-1:0]   = cfg.rd_incr;
            vread_pkg::REG_RD_ITER:   prdata_o[ADDR_W-1:0]   = cfg.rd_iter;
            vread_pkg::REG_RD_SHIFT:  prdata_o[ADDR_W-1:0]   = cfg.rd_shift;
            vread_pkg::REG_OUT_START: prdata_o[ADDR_W-1:0]   = cfg.out_start;
            vread_pkg::REG_OUT_PER:   prdata_o[PERIOD_W-1:0] = cfg.out_per;
            vread_pkg::REG_OUT_DUTY:  prdata_o[PERIOD_W-1:0] = cfg.out_duty;
            vread_pkg::REG_OUT_INCR:  prdata_o[ADDR_W-1:0]   = cfg.out_incr;
            vread_pkg::REG_OUT_ITER:  prdata_o[ADDR_W-1:0]   = cfg.out_iter;
            vread_pkg::REG_OUT_SHIFT: prdata_o[ADDR_W-1:0]   = cfg.out_shift;
            vread_pkg::REG_OUT_DELAY: prdata_o[DELAY_W-1:0]  = cfg.delay;
            default: ;
         endcase
      end
   end

endmodule

/* hdl/buf_mem_2p.sv */
`timescale 1ns/1ps

module buf_mem_2p #(
   parameter int ADDR_W = 10
) (
   input logic   clk,
   mem_2p_if.mem mem
);

   logic [vread_pkg::AXI_DATA_W-1:0] ram [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (mem.we) begin
         ram[mem.waddr] <= mem.wdata;
      end
   end

   // registered read, one cycle latency
   always_ff @(posedge clk) begin
      if (mem.re) begin
         mem.rdata <= ram[mem.raddr];
      end
   end

endmodule

/* hdl/vread_top.sv */
`timescale 1ns/1ps

module vread_top #(
   parameter int ADDR_W   = 10,
   parameter int PERIOD_W = 8,
   parameter int LEN_W    = 8,
   parameter int DELAY_W  = 7
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [vread_pkg::REG_ADDR_W-1:0] paddr_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0] pwdata_i,
   output logic [vread_pkg::AXI_DATA_W-1:0] prdata_o,
   output logic                             pready_o,
   output logic                             databus_valid_o,
   output logic [vread_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   output logic [LEN_W-1:0]                 databus_len_o,
   input  logic                             databus_ready_i,
   input  logic [vread_pkg::AXI_DATA_W-1:0] databus_rdata_i,
   input  logic                             databus_last_i,
   output logic                             out_valid_o,
   output logic [vread_pkg::SYM_W-1:0]      out_data_o,
   output logic                             done_o
);

   vread_cfg_if #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .LEN_W   (LEN_W),
      .DELAY_W (DELAY_W)
   ) cfg_bus ();

   mem_2p_if #(
      .ADDR_W(ADDR_W)
   ) buf_port ();

   vread_regs #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .LEN_W   (LEN_W),
      .DELAY_W (DELAY_W)
   ) regs0 (
      .clk      (clk),
      .rst      (rst),
      .psel_i   (psel_i),
      .penable_i(penable_i),
      .pwrite_i (pwrite_i),
      .paddr_i  (paddr_i),
      .pwdata_i (pwdata_i),
      .prdata_o (prdata_o),
      .pready_o (pready_o),
      .cfg      (cfg_bus.regs)
   );

   vread_unit #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .LEN_W   (LEN_W),
      .DELAY_W (DELAY_W)
   ) unit0 (
      .clk            (clk),
      .rst            (rst),
      .cfg            (cfg_bus.unit),
      .mem            (buf_port.ctrl),
      .databus_ready_i(databus_ready_i),
      .databus_rdata_i(databus_rdata_i),
      .databus_last_i (databus_last_i),
      .databus_valid_o(databus_valid_o),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .out_valid_o    (out_valid_o),
      .out_data_o     (out_data_o)
   );

   buf_mem_2p #(
      .ADDR_W(ADDR_W)
   ) buf0 (
      .clk(clk),
      .mem(buf_port.mem)
   );

   assign done_o = cfg_bus.done;

endmodule

/* verif/vread_tb.sv */
`timescale 1ns/1ps

module vread_tb;

   localparam int ADDR_W    = 10;
   localparam int PERIOD_W  = 8;
   localparam int LEN_W     = 8;
   localparam int DELAY_W   = 7;
   localparam int CLK_PER   = 40;
   localparam int NF        = 17;
   localparam int MAX_TESTS = 64;
   localparam int ADDR_MASK = (1 << ADDR_W) - 1;

   // trace columns, fields 1..14 follow the register map from EXT_ADDR on
   localparam int F_CTRL    = 0;
   localparam int F_EXT     = 1;
   localparam int F_RD_LEN  = 2;
   localparam int F_RD_PER  = 3;
   localparam int F_RD_DUTY = 4;
   localparam int F_RD_INCR = 5;
   localparam int F_RD_ITER = 6;
   localparam int F_RD_SHFT = 7;
   localparam int F_O_START = 8;
   localparam int F_O_PER   = 9;
   localparam int F_O_DUTY  = 10;
   localparam int F_O_INCR  = 11;
   localparam int F_O_ITER  = 12;
   localparam int F_O_SHFT  = 13;
   localparam int F_DELAY   = 14;
   localparam int F_COUNT   = 15;
   localparam int F_SUM     = 16;

   logic                             clk;
   logic                             rst;
   logic                             psel_i;
   logic                             penable_i;
   logic                             pwrite_i;
   logic [vread_pkg::REG_ADDR_W-1:0] paddr_i;
   logic [vread_pkg::AXI_DATA_W-1:0] pwdata_i;
   logic [vread_pkg::AXI_DATA_W-1:0] prdata_o;
   logic                             pready_o;
   logic                             databus_valid_o;
   logic [vread_pkg::AXI_ADDR_W-1:0] databus_addr_o;
   logic [LEN_W-1:0]                 databus_len_o;
   logic                             databus_ready_i;
   logic [vread_pkg::AXI_DATA_W-1:0] databus_rdata_i;
   logic                             databus_last_i;
   logic                             out_valid_o;
   logic [vread_pkg::SYM_W-1:0]      out_data_o;
   logic                             done_o;

   logic [31:0] trace_f [MAX_TESTS][NF];
   int          n_tests;
   int          limit_cycles;
   int          err_cnt;
   int          check_cnt;
   int          bus_seen;
   int          beat_k;
   int          cur_len;
   logic [15:0] captured [$];
   logic [15:0] expected [$];
   int          gen_q [$];
   logic [31:0] model_mem [1 << ADDR_W];
   logic        pp_model;

   vread_top #(
      .ADDR_W  (ADDR_W),
      .PERIOD_W(PERIOD_W),
      .LEN_W   (LEN_W),
      .DELAY_W (DELAY_W)
   ) dut0 (
      .clk            (clk),
      .rst            (rst),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .pready_o       (pready_o),
      .databus_valid_o(databus_valid_o),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .databus_ready_i(databus_ready_i),
      .databus_rdata_i(databus_rdata_i),
      .databus_last_i (databus_last_i),
      .out_valid_o    (out_valid_o),
      .out_data_o     (out_data_o),
      .done_o         (done_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PER / 2) clk = ~clk;
   end

   task automatic drive_slot();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] got_v);
      check_cnt++;
      if (got_v !== exp_v) begin
         err_cnt++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      drive_slot();
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      drive_slot();
      penable_i = 1'b1;
      @(negedge clk);
      check_value("pready_o", 32'h1, 32'(pready_o));
      drive_slot();
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      drive_slot();
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      drive_slot();
      penable_i = 1'b1;
      @(negedge clk);
      data = prdata_o;
      check_value("pready_o", 32'h1, 32'(pready_o));
      drive_slot();
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   // two-level walk, addresses kept only inside the duty window
   task automatic walk_addrs(input int start, input int per, input int duty,
                             input int incr, input int iter, input int shift);
      int base;
      int a;
      gen_q.delete();
      base = start;
      for (int i = 0; i < iter; i++) begin
         a = base;
         for (int p = 0; p < per; p++) begin
            if (p < duty) begin
               gen_q.push_back(a & ADDR_MASK);
            end
            a = a + incr;
         end
         base = base + shift;
      end
   endtask

   task automatic predict_run(input int t);
      logic        rd_en;
      logic        pp;
      logic        rd_half;
      logic        out_half;
      int          w;
      int          s;
      logic [31:0] word;
      rd_en    = trace_f[t][F_CTRL][vread_pkg::CTRL_READ_EN];
      pp       = trace_f[t][F_CTRL][vread_pkg::CTRL_PINGPONG];
      rd_half  = pp && !pp_model;
      out_half = pp && pp_model;
      if (rd_en) begin
         walk_addrs(int'(rd_half) << (ADDR_W - 1), trace_f[t][F_RD_PER],
                    trace_f[t][F_RD_DUTY], trace_f[t][F_RD_INCR],
                    trace_f[t][F_RD_ITER], trace_f[t][F_RD_SHFT]);
         for (int k = 0; k < int'(trace_f[t][F_RD_LEN]) && k < gen_q.size(); k++) begin
            model_mem[gen_q[k]] = trace_f[t][F_EXT] + 32'(4 * k);
         end
      end
      walk_addrs((int'(out_half) << (ADDR_W - 1)) | (trace_f[t][F_O_START] & 511),
                 trace_f[t][F_O_PER], trace_f[t][F_O_DUTY], trace_f[t][F_O_INCR],
                 trace_f[t][F_O_ITER], trace_f[t][F_O_SHFT]);
      expected.delete();
      foreach (gen_q[i]) begin
         s = gen_q[i];
         // symbol address to word address, half bit on top
         w = ((s >> 1) & 255) | ((pp && ((s >> 9) & 1) != 0) ? 512 : 0);
         word = model_mem[w];
         expected.push_back((s & 1) != 0 ? word[31:16] : word[15:0]);
      end
      pp_model = pp ? !pp_model : 1'b0;
   endtask

   task automatic load_trace();
      int    fd;
      int    n;
      string line;
      logic [31:0] f [NF];
      n_tests = 0;
      fd = $fopen("verif/vread_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file verif/vread_trace.txt");
         err_cnt++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != 8'h23 && n_tests < MAX_TESTS) begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                           f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
               if (n == NF) begin
                  for (int i = 0; i < NF; i++) begin
                     trace_f[n_tests][i] = f[i];
                  end
                  n_tests++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // bus responder, one beat per valid and ready cycle
   initial begin
      logic fire;
      void'($urandom(32'hfb1a7eba));
      forever begin
         @(negedge clk);
         fire = databus_valid_o && databus_ready_i;
         drive_slot();
         if (fire) begin
            beat_k = databus_last_i ? 0 : beat_k + 1;
         end
         databus_ready_i = ($urandom % 4) != 0;
         databus_rdata_i = databus_addr_o + 32'(4 * beat_k);
         databus_last_i  = (beat_k == int'(databus_len_o) - 1);
      end
   end

   // output and bus monitor
   initial begin
      forever begin
         @(negedge clk);
         if (out_valid_o) begin
            captured.push_back(out_data_o);
         end
         if (databus_valid_o) begin
            bus_seen++;
            check_value("databus_len_o", 32'(cur_len), 32'(databus_len_o));
         end
      end
   end

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout after %0d cycles, done_o never came back", limit_cycles);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      logic [31:0] rd;
      int          max_delay;
      int          max_beats;
      int          max_steps;
      int          sum;
      rst = 1'b1;
      psel_i = 1'b0;
      penable_i = 1'b0;
      pwrite_i = 1'b0;
      paddr_i = '0;
      pwdata_i = '0;
      databus_ready_i = 1'b0;
      databus_rdata_i = '0;
      databus_last_i = 1'b0;
      err_cnt = 0;
      check_cnt = 0;
      bus_seen = 0;
      beat_k = 0;
      cur_len = 0;
      pp_model = 1'b0;
      limit_cycles = 0;
      load_trace();
      max_delay = 0;
      max_beats = 0;
      max_steps = 0;
      for (int t = 0; t < n_tests; t++) begin
         max_delay = int'(trace_f[t][F_DELAY]) > max_delay ? trace_f[t][F_DELAY] : max_delay;
         max_beats = int'(trace_f[t][F_RD_LEN]) > max_beats ? trace_f[t][F_RD_LEN] : max_beats;
         sum = trace_f[t][F_O_PER] * trace_f[t][F_O_ITER];
         max_steps = sum > max_steps ? sum : max_steps;
      end
      // margin covers APB setup and ready gaps
      limit_cycles = n_tests * (max_delay + 2 * max_beats + max_steps + 90) + 20;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;

      check_value("prdata_o", 32'h0, prdata_o);
      apb_read(vread_pkg::REG_STATUS, rd);
      check_value("status", 32'h1, rd);
      check_value("done_o", 32'h1, 32'(done_o));
      check_value("out_valid count", 32'h0, 32'(captured.size()));
      check_value("bus valid count", 32'h0, 32'(bus_seen));

      for (int t = 0; t < n_tests; t++) begin
         predict_run(t);
         captured.delete();
         bus_seen = 0;
         cur_len = trace_f[t][F_RD_LEN];
         for (int i = F_EXT; i <= F_DELAY; i++) begin
            apb_write(vread_pkg::REG_EXT_ADDR + 8'(4 * (i - F_EXT)), trace_f[t][i]);
         end
         apb_write(vread_pkg::REG_CTRL, trace_f[t][F_CTRL]);
         // run is high for one cycle, done drops in the next
         repeat (2) @(negedge clk);
         check_value("done_o after run", 32'h0, 32'(done_o));
         while (!done_o) begin
            @(negedge clk);
         end
         check_value("out count", trace_f[t][F_COUNT], 32'(captured.size()));
         check_value("model count", trace_f[t][F_COUNT], 32'(expected.size()));
         sum = 0;
         foreach (captured[i]) begin
            sum = sum + int'(captured[i]) * i;
            if (i < expected.size()) begin
               check_value($sformatf("out_data_o[%0d]", i), 32'(expected[i]),
                           32'(captured[i]));
            end
         end
         check_value("checksum", trace_f[t][F_SUM], 32'(sum));
         sum = 0;
         foreach (expected[i]) begin
            sum = sum + int'(expected[i]) * i;
         end
         check_value("model checksum", trace_f[t][F_SUM], 32'(sum));
         if (trace_f[t][F_CTRL][vread_pkg::CTRL_READ_EN]) begin
            check_cnt++;
            if (bus_seen < cur_len) begin
               err_cnt++;
               $display("test %0d saw fewer bus valid cycles than beats", t);
            end
         end else begin
            check_value("bus valid count", 32'h0, 32'(bus_seen));
         end
         apb_read(vread_pkg::REG_CTRL, rd);
         check_value("ctrl", trace_f[t][F_CTRL] & 32'h6, rd);
      end

      $display("checks %0d, errors %0d, tests %0d", check_cnt, err_cnt, n_tests);
      if (err_cnt == 0 && n_tests > 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* verif/vread_trace.txt */
# ctrl ext_addr rd_len rd_per rd_duty rd_incr rd_iter rd_shift out_start out_per
# out_duty out_incr out_iter out_shift delay exp_count exp_checksum (all hex)
3 00010000 4 4 4 1 1 0 0 8 8 1 1 0 64 8 80
3 00020000 6 4 2 1 3 8 0 4 3 1 3 10 64 9 174
3 00030100 10 10 10 1 1 0 0 10 10 2 1 0 64 10 8b60
7 00040000 4 4 4 1 1 0 0 4 4 1 1 0 64 4 214
7 00050000 2 2 2 1 1 0 0 8 8 1 1 0 64 8 b0
1 00000000 0 1 1 1 1 0 0 4 4 1 1 0 5 4 1c

/* vread_top.f */
hdl/vread_pkg.sv
hdl/vread_ifs.sv
hdl/addr_gen.sv
hdl/mem_writer.sv
hdl/vread_unit.sv
hdl/vread_regs.sv
hdl/buf_mem_2p.sv
hdl/vread_top.sv
verif/vread_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vread_tb
FILELIST  ?= vread_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
